/* files.f */
logic/periph_pkg.sv
logic/periph_bus_bridge.sv
logic/periph_timer.sv
logic/periph_gpio.sv
logic/periph_irq_ctrl.sv
logic/peripheral_subsystem.sv
tb/peripheral_subsystem_tb.sv

/* logic/periph_bus_bridge.sv */
/*
 * Bus bridge: accepts one request at a time, issues a register access
 * to the addressed peripheral and returns the response
 */
`timescale 1ns/1ps

module periph_bus_bridge (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                bus_req_valid_i,
  input  periph_pkg::bus_req_t bus_req_i,
  output logic                bus_req_ready_o,
  output logic                bus_rsp_valid_o,
  output periph_pkg::bus_rsp_t bus_rsp_o,
  input  logic                bus_rsp_ready_i,
  output logic                bus_error_o,
  output periph_pkg::reg_req_t gpio_req_o,
  output periph_pkg::reg_req_t timer_req_o,
  output periph_pkg::reg_req_t irq_req_o,
  input  periph_pkg::reg_rsp_t gpio_rsp_i,
  input  periph_pkg::reg_rsp_t timer_rsp_i,
  input  periph_pkg::reg_rsp_t irq_rsp_i
);

  import periph_pkg::*;

  bridge_state_e state_q, state_d;
  bus_req_t      req_q;
  bus_rsp_t      rsp_q;
  periph_sel_t   sel;
  reg_req_t      access;
  logic          in_access;
  logic          hit;
  data_t         sel_rdata;

  assign sel       = req_q.addr[15:12];
  assign in_access = (state_q == ACCESS);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (bus_req_valid_i) state_d = ACCESS;
      ACCESS:  state_d = RESPOND;
      RESPOND: if (bus_rsp_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request is only taken in IDLE, so it stays put through the access
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && bus_req_valid_i) begin
      req_q <= bus_req_i;
    end
  end

  // Shared access fields; valid goes only to the decoded peripheral
  always_comb begin
    access.valid = 1'b0;
    access.write = req_q.we;
    access.idx   = req_q.addr[5:2];
    access.wdata = req_q.wdata;
    gpio_req_o        = access;
    timer_req_o       = access;
    irq_req_o         = access;
    gpio_req_o.valid  = in_access && (sel == SEL_GPIO);
    timer_req_o.valid = in_access && (sel == SEL_TIMER);
    irq_req_o.valid   = in_access && (sel == SEL_IRQ);
  end

  always_comb begin
    hit       = 1'b1;
    sel_rdata = BAD_ACCESS_DATA;
    unique case (sel)
      SEL_GPIO:  sel_rdata = gpio_rsp_i.rdata;
      SEL_TIMER: sel_rdata = timer_rsp_i.rdata;
      SEL_IRQ:   sel_rdata = irq_rsp_i.rdata;
      default:   hit = 1'b0;
    endcase
  end

  // Reply captured at the end of ACCESS, held through back-pressure
  always_ff @(posedge clk_i) begin
    if (in_access) begin
      rsp_q.error <= !hit;
      rsp_q.rdata <= req_q.we ? '0 : sel_rdata;
    end
  end

  assign bus_req_ready_o = (state_q == IDLE);
  assign bus_rsp_valid_o = (state_q == RESPOND);
  assign bus_rsp_o       = rsp_q;
  assign bus_error_o     = bus_rsp_valid_o && bus_rsp_ready_i && rsp_q.error;

endmodule : periph_bus_bridge

/* logic/periph_gpio.sv */
/*
 * GPIO block with input synchronizer and per-pin level interrupts
 */
`timescale 1ns/1ps

module periph_gpio #(
  parameter int unsigned GPIO_W = 8
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic [GPIO_W-1:0]   gpio_i,
  output logic [GPIO_W-1:0]   gpio_o,
  output logic [GPIO_W-1:0]   gpio_oe_o,
  output logic [GPIO_W-1:0]   gpio_intr_o
);

  import periph_pkg::*;

  localparam reg_idx_t REG_IN      = 4'd0;
  localparam reg_idx_t REG_OUT     = 4'd1;
  localparam reg_idx_t REG_OE      = 4'd2;
  localparam reg_idx_t REG_INTR_EN = 4'd3;

  logic [GPIO_W-1:0] sync_meta_q;
  logic [GPIO_W-1:0] sync_in_q;
  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] oe_q;
  logic [GPIO_W-1:0] intr_en_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_meta_q <= '0;
      sync_in_q   <= '0;
      out_q       <= '0;
      oe_q        <= '0;
      intr_en_q   <= '0;
    end else begin
      sync_meta_q <= gpio_i;
      sync_in_q   <= sync_meta_q;
      if (reg_req_i.valid && reg_req_i.write) begin
        unique case (reg_req_i.idx)
          REG_OUT:     out_q     <= reg_req_i.wdata[GPIO_W-1:0];
          REG_OE:      oe_q      <= reg_req_i.wdata[GPIO_W-1:0];
          REG_INTR_EN: intr_en_q <= reg_req_i.wdata[GPIO_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    unique case (reg_req_i.idx)
      REG_IN:      reg_rsp_o.rdata = data_t'(sync_in_q);
      REG_OUT:     reg_rsp_o.rdata = data_t'(out_q);
      REG_OE:      reg_rsp_o.rdata = data_t'(oe_q);
      REG_INTR_EN: reg_rsp_o.rdata = data_t'(intr_en_q);
      default:     reg_rsp_o.rdata = '0;
    endcase
  end

  assign gpio_o      = out_q;
  assign gpio_oe_o   = oe_q;
  assign gpio_intr_o = sync_in_q & intr_en_q;

endmodule : periph_gpio

/* logic/periph_irq_ctrl.sv */
/*
 * Interrupt controller: pending and enable registers, lowest-ID claim
 * and a software interrupt bit
 */
`timescale 1ns/1ps

module periph_irq_ctrl #(
  parameter int unsigned NUM_SRC = 11
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic [NUM_SRC-1:0]  intr_src_i,
  output logic                irq_o,
  output logic                msip_o
);

  import periph_pkg::*;

  localparam reg_idx_t REG_ENABLE  = 4'd0;
  localparam reg_idx_t REG_PENDING = 4'd1;
  localparam reg_idx_t REG_CLAIM   = 4'd2;
  localparam reg_idx_t REG_MSIP    = 4'd3;

  logic [NUM_SRC-1:0] enable_q;
  logic [NUM_SRC-1:0] pending_q;
  logic [NUM_SRC-1:0] active;
  data_t              claim_id;
  logic               irq_q;
  logic               msip_q;

  assign active = pending_q & enable_q;

  // Lowest active ID wins, ID 0 means nothing pending
  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (active[i]) begin
        claim_id = data_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q  <= '0;
      pending_q <= '0;
      irq_q     <= 1'b0;
      msip_q    <= 1'b0;
    end else begin
      pending_q <= {intr_src_i[NUM_SRC-1:1], 1'b0};
      irq_q     <= |active;
      if (reg_req_i.valid && reg_req_i.write) begin
        unique case (reg_req_i.idx)
          REG_ENABLE: enable_q <= reg_req_i.wdata[NUM_SRC-1:0];
          REG_MSIP:   msip_q   <= reg_req_i.wdata[0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    unique case (reg_req_i.idx)
      REG_ENABLE:  reg_rsp_o.rdata = data_t'(enable_q);
      REG_PENDING: reg_rsp_o.rdata = data_t'(pending_q);
      REG_CLAIM:   reg_rsp_o.rdata = claim_id;
      REG_MSIP:    reg_rsp_o.rdata = data_t'(msip_q);
      default:     reg_rsp_o.rdata = '0;
    endcase
  end

  assign irq_o  = irq_q;
  assign msip_o = msip_q;

endmodule : periph_irq_ctrl

/* logic/periph_pkg.sv */
/*
 * Peripheral subsystem package
 * Bus and register access types, address map and bridge states
 */
package periph_pkg;

  typedef logic [15:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [3:0]  periph_sel_t;

  // Bus request channel payload
  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  error;
  } bus_rsp_t;

  // Single-cycle register access toward one peripheral
  typedef struct packed {
    logic     valid;
    logic     write;
    reg_idx_t idx;
    data_t    wdata;
  } reg_req_t;

  typedef struct packed {
    data_t rdata;
  } reg_rsp_t;

  // Address map, selected by addr[15:12]
  localparam periph_sel_t SEL_GPIO  = 4'd0;
  localparam periph_sel_t SEL_TIMER = 4'd1;
  localparam periph_sel_t SEL_IRQ   = 4'd2;

  localparam data_t BAD_ACCESS_DATA = 32'hBADA55E5;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESPOND
  } bridge_state_e;

endpackage : periph_pkg

/* logic/periph_timer.sv */
/*
 * Timer with prescaler, writable count and compare level interrupt
 */
`timescale 1ns/1ps

module periph_timer (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                timer_irq_o
);

  import periph_pkg::*;

  localparam reg_idx_t REG_CTRL     = 4'd0;
  localparam reg_idx_t REG_PRESCALE = 4'd1;
  localparam reg_idx_t REG_COUNT    = 4'd2;
  localparam reg_idx_t REG_COMPARE  = 4'd3;

  logic  enable_q;
  data_t prescale_q;
  data_t tick_q;
  data_t count_q;
  data_t compare_q;
  logic  irq_q;
  logic  wr_en;

  assign wr_en = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      enable_q   <= 1'b0;
      prescale_q <= '0;
      tick_q     <= '0;
      count_q    <= '0;
      compare_q  <= '0;
      irq_q      <= 1'b0;
    end else begin
      // One count step every prescale_q + 1 enabled cycles
      if (!enable_q) begin
        tick_q <= '0;
      end else if (tick_q >= prescale_q) begin
        tick_q  <= '0;
        count_q <= count_q + 1'b1;
      end else begin
        tick_q <= tick_q + 1'b1;
      end
      // Software write to COUNT takes priority over the increment
      if (wr_en) begin
        unique case (reg_req_i.idx)
          REG_CTRL:     enable_q   <= reg_req_i.wdata[0];
          REG_PRESCALE: prescale_q <= reg_req_i.wdata;
          REG_COUNT:    count_q    <= reg_req_i.wdata;
          REG_COMPARE:  compare_q  <= reg_req_i.wdata;
          default: ;
        endcase
      end
      irq_q <= enable_q && (count_q >= compare_q);
    end
  end

  always_comb begin
    unique case (reg_req_i.idx)
      REG_CTRL:     reg_rsp_o.rdata = data_t'(enable_q);
      REG_PRESCALE: reg_rsp_o.rdata = prescale_q;
      REG_COUNT:    reg_rsp_o.rdata = count_q;
      REG_COMPARE:  reg_rsp_o.rdata = compare_q;
      default:      reg_rsp_o.rdata = '0;
    endcase
  end

  assign timer_irq_o = irq_q;

endmodule : periph_timer

/* logic/peripheral_subsystem.sv */
/*
 * Peripheral subsystem: bus bridge with GPIO, timer and interrupt controller
 */
`timescale 1ns/1ps

module peripheral_subsystem #(
  parameter int unsigned GPIO_W = 8
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                bus_req_valid_i,
  input  periph_pkg::bus_req_t bus_req_i,
  output logic                bus_req_ready_o,
  output logic                bus_rsp_valid_o,
  output periph_pkg::bus_rsp_t bus_rsp_o,
  input  logic                bus_rsp_ready_i,
  output logic                bus_error_o,
  input  logic [GPIO_W-1:0]   gpio_i,
  output logic [GPIO_W-1:0]   gpio_o,
  output logic [GPIO_W-1:0]   gpio_oe_o,
  input  logic                ext_intr_i,
  output logic                timer_irq_o,
  output logic                irq_o,
  output logic                msip_o
);

  import periph_pkg::*;

  // ID 0 reserved, then GPIO pins, timer, external
  localparam int unsigned NUM_SRC = GPIO_W + 3;

  reg_req_t           gpio_req, timer_req, irq_req;
  reg_rsp_t           gpio_rsp, timer_rsp, irq_rsp;
  logic [GPIO_W-1:0]  gpio_intr;
  logic [NUM_SRC-1:0] intr_src;

  assign intr_src = {ext_intr_i, timer_irq_o, gpio_intr, 1'b0};

  periph_bus_bridge bus_bridge_i (
    .clk_i, .arst_n_i,
    .bus_req_valid_i, .bus_req_i, .bus_req_ready_o,
    .bus_rsp_valid_o, .bus_rsp_o, .bus_rsp_ready_i,
    .bus_error_o,
    .gpio_req_o (gpio_req),
    .timer_req_o(timer_req),
    .irq_req_o  (irq_req),
    .gpio_rsp_i (gpio_rsp),
    .timer_rsp_i(timer_rsp),
    .irq_rsp_i  (irq_rsp)
  );

  periph_gpio #(.GPIO_W(GPIO_W)) periph_gpio_i (
    .clk_i, .arst_n_i,
    .reg_req_i  (gpio_req),
    .reg_rsp_o  (gpio_rsp),
    .gpio_i, .gpio_o, .gpio_oe_o,
    .gpio_intr_o(gpio_intr)
  );

  periph_timer periph_timer_i (
    .clk_i, .arst_n_i,
    .reg_req_i  (timer_req),
    .reg_rsp_o  (timer_rsp),
    .timer_irq_o
  );

  periph_irq_ctrl #(.NUM_SRC(NUM_SRC)) periph_irq_ctrl_i (
    .clk_i, .arst_n_i,
    .reg_req_i (irq_req),
    .reg_rsp_o (irq_rsp),
    .intr_src_i(intr_src),
    .irq_o, .msip_o
  );

endmodule : peripheral_subsystem

/* run.sh */
#!/usr/bin/env bash
# Build and run the peripheral subsystem testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module peripheral_subsystem_tb -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* tb/peripheral_subsystem_tb.sv */
/*
 * Testbench for the peripheral subsystem with directed GPIO, timer,
 * interrupt controller and unmapped access checks under back-pressure
 */
`timescale 1ns/1ps

module peripheral_subsystem_tb;

  import periph_pkg::*;

  localparam int unsigned GPIO_W      = 8;
  localparam int unsigned CLK_PERIOD  = 4;
  localparam int unsigned MAX_STALL   = 6;
  localparam int unsigned NUM_XFERS   = 70;
  localparam int unsigned XFER_CYCLES = 16;
  localparam int unsigned WAIT_CYCLES = 60;
  localparam int unsigned WATCHDOG_NS = (NUM_XFERS * XFER_CYCLES + WAIT_CYCLES) * CLK_PERIOD;

  logic              clk;
  logic              arst_n;
  logic              bus_req_valid;
  bus_req_t          bus_req;
  logic              bus_req_ready_o;
  logic              bus_rsp_valid_o;
  bus_rsp_t          bus_rsp_o;
  logic              bus_rsp_ready;
  logic              bus_error_o;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_o;
  logic [GPIO_W-1:0] gpio_oe_o;
  logic              ext_intr;
  logic              timer_irq_o;
  logic              irq_o;
  logic              msip_o;

  logic              stall_en;
  logic              last_timer_irq;
  logic              held_valid;
  bus_rsp_t          held_rsp;
  logic              req_outstanding;

  peripheral_subsystem #(.GPIO_W(GPIO_W)) peripheral_subsystem_i (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .bus_req_valid_i(bus_req_valid),
    .bus_req_i      (bus_req),
    .bus_req_ready_o,
    .bus_rsp_valid_o,
    .bus_rsp_o,
    .bus_rsp_ready_i(bus_rsp_ready),
    .bus_error_o,
    .gpio_i         (gpio_in),
    .gpio_o,
    .gpio_oe_o,
    .ext_intr_i     (ext_intr),
    .timer_irq_o,
    .irq_o,
    .msip_o
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic stop_with_failure();
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    stop_with_failure();
  endtask

  task automatic check_eq(input string test, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("** Error [%s] expected %0h actual %0h", test, exp, act);
      stop_with_failure();
    end
  endtask

  function automatic addr_t reg_addr(input logic [3:0] sel, input logic [3:0] idx);
    return {sel, 6'd0, idx, 2'd0};
  endfunction

  // One full request and response, starting on a rising edge
  task automatic bus_access(input addr_t addr, input logic we, input data_t wdata,
                            input logic exp_err, output bus_rsp_t rsp);
    bus_req_t    req;
    int unsigned stalls;
    logic        done;
    req.addr  = addr;
    req.we    = we;
    req.wdata = wdata;
    stalls    = 0;
    done      = 1'b0;
    bus_req_valid <= 1'b1;
    bus_req       <= req;
    @(posedge clk);
    while (!bus_req_ready_o) @(posedge clk);
    bus_req_valid <= 1'b0;
    bus_rsp_ready <= !stall_en || ($urandom_range(0, 2) == 0);
    while (!done) begin
      @(posedge clk);
      if (bus_rsp_valid_o && bus_rsp_ready) begin
        rsp            = bus_rsp_o;
        last_timer_irq = timer_irq_o;
        done           = 1'b1;
        check_eq("bus_error at transfer", exp_err, bus_error_o);
        bus_rsp_ready <= 1'b0;
      end else begin
        if (bus_rsp_valid_o) stalls++;
        bus_rsp_ready <= !stall_en || stalls >= MAX_STALL || ($urandom_range(0, 2) == 0);
      end
    end
  endtask

  task automatic bus_write(input string test, input addr_t addr, input data_t wdata);
    bus_rsp_t rsp;
    bus_access(addr, 1'b1, wdata, 1'b0, rsp);
    check_eq({test, " write error"}, 0, rsp.error);
    check_eq({test, " write rdata"}, 0, rsp.rdata);
  endtask

  task automatic bus_read(input string test, input addr_t addr, output data_t rdata);
    bus_rsp_t rsp;
    bus_access(addr, 1'b0, '0, 1'b0, rsp);
    check_eq({test, " read error"}, 0, rsp.error);
    rdata = rsp.rdata;
  endtask

  // Response stability and handshake rules on every edge
  always @(posedge clk) begin
    if (arst_n) begin
      if (held_valid) begin
        check_eq("rsp valid held under back-pressure", 1, bus_rsp_valid_o);
        check_eq("rsp held under back-pressure", held_rsp, bus_rsp_o);
      end
      if (req_outstanding || bus_rsp_valid_o) begin
        check_eq("req ready low until response transfer", 0, bus_req_ready_o);
      end
      assert (!bus_error_o || (bus_rsp_valid_o && bus_rsp_ready))
        else abort_run("bus_error_o was high outside a response transfer");
    end
    if (bus_req_valid && bus_req_ready_o) req_outstanding = 1'b1;
    if (bus_rsp_valid_o && bus_rsp_ready) req_outstanding = 1'b0;
    held_valid = bus_rsp_valid_o && !bus_rsp_ready;
    held_rsp   = bus_rsp_o;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    stop_with_failure();
  end

  initial begin
    data_t             out_val;
    data_t             oe_val;
    data_t             rdata;
    data_t             count;
    logic [GPIO_W-1:0] pins;
    logic [GPIO_W-1:0] en;
    int unsigned       pin;
    int unsigned       polls;
    bus_rsp_t          rsp;
    void'($urandom(32'hde3e));
    clk             = 1'b0;
    arst_n          = 1'b0;
    bus_req_valid   = 1'b0;
    bus_req         = '0;
    bus_rsp_ready   = 1'b0;
    gpio_in         = '0;
    ext_intr        = 1'b0;
    stall_en        = 1'b1;
    held_valid      = 1'b0;
    held_rsp        = '0;
    req_outstanding = 1'b0;
    repeat (2) @(posedge clk);
    check_eq("reset req ready", 1, bus_req_ready_o);
    check_eq("reset rsp valid", 0, bus_rsp_valid_o);
    check_eq("reset bus error", 0, bus_error_o);
    check_eq("reset gpio out", 0, {gpio_o, gpio_oe_o});
    check_eq("reset irq outputs", 0, {timer_irq_o, irq_o, msip_o});
    arst_n <= 1'b1;
    @(posedge clk);

    // GPIO outputs
    repeat (4) begin
      out_val = $urandom;
      oe_val  = $urandom;
      bus_write("gpio OUT", reg_addr(4'd0, 4'd1), out_val);
      bus_write("gpio OE", reg_addr(4'd0, 4'd2), oe_val);
      check_eq("gpio_o", out_val[GPIO_W-1:0], gpio_o);
      check_eq("gpio_oe_o", oe_val[GPIO_W-1:0], gpio_oe_o);
      bus_read("gpio OUT", reg_addr(4'd0, 4'd1), rdata);
      check_eq("gpio OUT readback", out_val[GPIO_W-1:0], rdata);
    end

    // GPIO inputs through the synchronizer into PENDING
    pins = GPIO_W'($urandom);
    en   = GPIO_W'($urandom);
    gpio_in <= pins;
    repeat (3) @(posedge clk);
    bus_read("gpio IN", reg_addr(4'd0, 4'd0), rdata);
    check_eq("gpio IN", pins, rdata);
    bus_write("gpio INTR_EN", reg_addr(4'd0, 4'd3), data_t'(en));
    bus_read("irq PENDING", reg_addr(4'd2, 4'd1), rdata);
    check_eq("irq PENDING gpio", {pins & en, 1'b0}, rdata);

    // Timer without back-pressure so the transfer edge follows the count sample
    stall_en = 1'b0;
    bus_write("timer PRESCALE", reg_addr(4'd1, 4'd1), 32'd0);
    bus_write("timer COMPARE", reg_addr(4'd1, 4'd3), 32'd20);
    bus_write("timer COUNT", reg_addr(4'd1, 4'd2), 32'd0);
    bus_write("timer CTRL", reg_addr(4'd1, 4'd0), 32'd1);
    count = '0;
    polls = 0;
    while (count < 20 && polls < 30) begin
      bus_read("timer COUNT", reg_addr(4'd1, 4'd2), count);
      polls++;
      if (count < 20) check_eq("timer irq below compare", 0, last_timer_irq);
    end
    assert (count >= 20) else abort_run("Timer count never reached the compare value");
    check_eq("timer irq at compare", 1, last_timer_irq);
    repeat (8) begin
      @(posedge clk);
      check_eq("timer irq held", 1, timer_irq_o);
    end
    bus_write("timer CTRL off", reg_addr(4'd1, 4'd0), 32'd0);
    stall_en = 1'b1;

    // Interrupt controller claim order and software interrupt
    bus_write("irq ENABLE", reg_addr(4'd2, 4'd0), '1);
    bus_write("gpio INTR_EN all", reg_addr(4'd0, 4'd3), '1);
    pin  = $urandom_range(0, GPIO_W - 1);
    pins = '0;
    pins[pin] = 1'b1;
    gpio_in  <= pins;
    ext_intr <= 1'b1;
    repeat (5) @(posedge clk);
    bus_read("irq CLAIM", reg_addr(4'd2, 4'd2), rdata);
    check_eq("irq CLAIM gpio pin", pin + 1, rdata);
    check_eq("irq_o with gpio pending", 1, irq_o);
    gpio_in <= '0;
    repeat (5) @(posedge clk);
    bus_read("irq CLAIM", reg_addr(4'd2, 4'd2), rdata);
    check_eq("irq CLAIM external", GPIO_W + 2, rdata);
    bus_write("irq MSIP", reg_addr(4'd2, 4'd3), 32'd1);
    check_eq("msip_o", 1, msip_o);
    ext_intr <= 1'b0;

    // Unmapped select
    bus_access(reg_addr(4'd5, 4'd0), 1'b0, '0, 1'b1, rsp);
    check_eq("unmapped read rdata", 32'hBADA55E5, rsp.rdata);
    check_eq("unmapped read error", 1, rsp.error);
    bus_access(reg_addr(4'd5, 4'd1), 1'b1, $urandom, 1'b1, rsp);
    check_eq("unmapped write error", 1, rsp.error);
    check_eq("unmapped write rdata", 0, rsp.rdata);

    // Back-pressure on mixed traffic
    repeat (6) begin
      out_val = $urandom;
      bus_write("stall OUT", reg_addr(4'd0, 4'd1), out_val);
      bus_read("stall OUT", reg_addr(4'd0, 4'd1), rdata);
      check_eq("stall OUT readback", out_val[GPIO_W-1:0], rdata);
    end

    repeat (2) @(posedge clk);
    $display("Simulation passed");
    $finish;
  end

endmodule : peripheral_subsystem_tb
